// ==== verilog.f ====
ds18b20Pkg.sv
slotTimer.sv
oneWireSequencer.sv
busBitEngine.sv
tempScaler.sv
ds18b20Driver.sv
sensorModel.sv
tbDs18b20.sv

// ==== Makefile ====
TOP := tbDs18b20

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module ds18b20Driver -f verilog.f

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f verilog.f -o simv
	@out="$$(./obj_dir/simv)"; echo "$$out"; echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

// ==== tbDs18b20.sv ====
`timescale 1ns/100ps

module tbDs18b20;

    localparam int CONV_WAIT_US = 200;
    localparam int NUM_SAMPLES  = 12;
    // two resets, three slot words and the wait per sample
    localparam int SAMPLE_CYCLES = 2 * 1001 + 3 * 16 * 63 + CONV_WAIT_US + 1;
    localparam int CYCLE_LIMIT   = NUM_SAMPLES * SAMPLE_CYCLES * 12 / 10;

    typedef struct packed {
        logic [15:0] raw;
        logic        presenceOn;
    } stimEntry_t;

    logic        clk1M;
    logic        rst;
    logic        busIn;
    logic        busDrive;
    logic [15:0] tempOut;
    logic        tempNegative;
    logic        sampleValid;
    logic        pullLow;
    logic [15:0] rawWord;
    logic        presenceEnable;
    logic [15:0] cmdWord;
    logic        cmdStrobe;
    int          resetCount;

    stimEntry_t  stim [NUM_SAMPLES];
    logic [15:0] cmdLog [$];
    int          pulseCount     = 0;
    int          valueErrors    = 0;
    int          protocolErrors = 0;
    int          cycleCount     = 0;
    int          waitGap        = 0;
    logic        gapArmed       = 1'b0;

    // wired-and with the pull-up
    assign busIn = !(busDrive || pullLow);

    ds18b20Driver #(
        .convWaitUs(CONV_WAIT_US)
    ) DUT (
        .clk1M       (clk1M),
        .rst         (rst),
        .busIn       (busIn),
        .busDrive    (busDrive),
        .tempOut     (tempOut),
        .tempNegative(tempNegative),
        .sampleValid (sampleValid)
    );

    sensorModel sensor (
        .clk1M         (clk1M),
        .rst           (rst),
        .busLine       (busIn),
        .rawWord       (rawWord),
        .presenceEnable(presenceEnable),
        .pullLow       (pullLow),
        .cmdWord       (cmdWord),
        .cmdStrobe     (cmdStrobe),
        .resetCount    (resetCount)
    );

    initial begin
        clk1M = 1'b0;
        forever begin
            #2 clk1M = ~clk1M;
        end
    end

    function automatic logic [31:0] lcgNext(logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // magnitude times 6.25 with the fraction dropped
    function automatic logic [15:0] expectedHundredths(int sixteenths);
        int mag;
        mag = (sixteenths < 0) ? -sixteenths : sixteenths;
        return 16'(mag * 625 / 100);
    endfunction

    task automatic loadStimulus();
        logic [31:0] seed;
        int          value;
        seed = 32'd72;
        stim[0] = '{raw: 16'h0191, presenceOn: 1'b1};
        stim[1] = '{raw: 16'h07D0, presenceOn: 1'b1};
        // no sensor answer before these two
        stim[2] = '{raw: 16'h0000, presenceOn: 1'b0};
        stim[3] = '{raw: 16'hFF5E, presenceOn: 1'b1};
        stim[4] = '{raw: 16'hFC90, presenceOn: 1'b1};
        stim[5] = '{raw: 16'h0008, presenceOn: 1'b1};
        stim[6] = '{raw: 16'hFFF8, presenceOn: 1'b0};
        stim[7] = '{raw: 16'h0550, presenceOn: 1'b1};
        // random readings within -55 to +125 degrees
        for (int k = 8; k < NUM_SAMPLES; k++) begin
            seed = lcgNext(seed);
            value = int'(seed[30:16]) % 2881 - 880;
            stim[k] = '{raw: 16'(value), presenceOn: 1'b1};
        end
    endtask

    task automatic checkSample(input int idx);
        int          value;
        logic [15:0] expOut;
        logic        expNeg;
        value  = int'($signed(stim[idx].raw));
        expOut = expectedHundredths(value);
        expNeg = (value < 0);
        if (tempOut !== expOut) begin
            $display("MISMATCH tempOut: raw 0x%04h expected 0x%04h got 0x%04h",
                     stim[idx].raw, expOut, tempOut);
            valueErrors++;
        end
        if (tempNegative !== expNeg) begin
            $display("MISMATCH tempNegative: raw 0x%04h expected 0x%0h got 0x%0h",
                     stim[idx].raw, expNeg, tempNegative);
            valueErrors++;
        end
        // skip rom + convert followed by skip rom + read scratchpad
        if (cmdLog.size() != 2) begin
            $display("sample %0d came after %0d commands instead of two", idx, cmdLog.size());
            protocolErrors++;
        end else begin
            if (cmdLog[0] !== 16'h44CC) begin
                $display("MISMATCH cmdWord: expected 0x44cc got 0x%04h", cmdLog[0]);
                protocolErrors++;
            end
            if (cmdLog[1] !== 16'hBECC) begin
                $display("MISMATCH cmdWord: expected 0xbecc got 0x%04h", cmdLog[1]);
                protocolErrors++;
            end
        end
        if (pulseCount != idx) begin
            $display("sample %0d saw %0d earlier sampleValid pulses", idx, pulseCount);
            protocolErrors++;
        end
        cmdLog.delete();
    endtask

    // pulse count, command log, released bus while converting
    always @(posedge clk1M) begin
        if (sampleValid) begin
            pulseCount <= pulseCount + 1;
        end
        if (cmdStrobe) begin
            cmdLog.push_back(cmdWord);
        end
        if (cmdStrobe && (cmdWord == 16'h44CC)) begin
            gapArmed <= 1'b1;
            waitGap  <= 0;
        end else if (gapArmed && !busDrive) begin
            waitGap <= waitGap + 1;
        end else if (gapArmed) begin
            gapArmed <= 1'b0;
            if (waitGap < CONV_WAIT_US) begin
                $display("bus driven after only %0d cycles of conversion wait", waitGap);
                protocolErrors++;
            end
        end
    end

    initial begin : watchdog
        while (cycleCount < CYCLE_LIMIT) begin
            @(posedge clk1M);
            cycleCount++;
        end
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("errors: value %0d, protocol %0d", valueErrors, protocolErrors);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin : stimulus
        int startResets;
        int startPulses;
        rst = 1'b0;
        presenceEnable = 1'b1;
        loadStimulus();
        rawWord = stim[0].raw;
        repeat (2) @(posedge clk1M);
        rst <= 1'b1;
        for (int idx = 0; idx < NUM_SAMPLES; idx++) begin
            @(posedge clk1M);
            rawWord        <= stim[idx].raw;
            presenceEnable <= stim[idx].presenceOn;
            if (!stim[idx].presenceOn) begin
                // silent sensor so resets repeat with no sample
                @(negedge clk1M);
                startResets = resetCount;
                startPulses = pulseCount;
                while (resetCount < startResets + 3) begin
                    @(negedge clk1M);
                end
                if (pulseCount != startPulses) begin
                    $display("sampleValid pulsed while the sensor gave no presence");
                    protocolErrors++;
                end
                @(posedge clk1M);
                presenceEnable <= 1'b1;
            end
            @(negedge clk1M);
            while (!sampleValid) begin
                @(negedge clk1M);
            end
            checkSample(idx);
        end
        repeat (4) @(negedge clk1M);
        if (pulseCount != NUM_SAMPLES) begin
            $display("%0d sampleValid pulses for %0d words", pulseCount, NUM_SAMPLES);
            protocolErrors++;
        end
        $display("errors: value %0d, protocol %0d", valueErrors, protocolErrors);
        if ((valueErrors == 0) && (protocolErrors == 0)) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== sensorModel.sv ====
`timescale 1ns/100ps

module sensorModel (
    input  logic        clk1M,
    input  logic        rst,
    input  logic        busLine,
    input  logic [15:0] rawWord,
    input  logic        presenceEnable,
    output logic        pullLow,
    output logic [15:0] cmdWord,
    output logic        cmdStrobe,
    output int          resetCount
);

    typedef enum logic [1:0] {
        IDLE,
        RX_CMD,
        TX_DATA
    } modelMode_e;

    modelMode_e  mode;
    int          lowCycles;
    int          presenceTimer;
    int          readPull;
    logic [3:0]  bitCount;
    logic [15:0] rxShift;
    logic [15:0] txWord;
    logic        masterLow;
    logic        rxBit;

    // line low while the model is quiet, so the master pulls
    assign masterLow = !busLine && !pullLow;
    // long low pulse is a 0
    assign rxBit = (lowCycles <= 15);
    // presence after a 30 cycle pause, or a 0 read bit
    assign pullLow = ((presenceTimer >= 1) && (presenceTimer <= 100)) || (readPull > 0);

    always @(posedge clk1M) begin
        if (!rst) begin
            mode          <= IDLE;
            lowCycles     <= 0;
            presenceTimer <= 0;
            readPull      <= 0;
            bitCount      <= '0;
            rxShift       <= '0;
            txWord        <= '0;
            cmdWord       <= '0;
            cmdStrobe     <= 1'b0;
            resetCount    <= 0;
        end else begin
            cmdStrobe <= 1'b0;
            if (presenceTimer > 0) begin
                presenceTimer <= presenceTimer - 1;
            end
            if (readPull > 0) begin
                readPull <= readPull - 1;
            end
            if (masterLow) begin
                lowCycles <= lowCycles + 1;
                // falling edge of a read slot, serve the next bit
                if ((lowCycles == 0) && (mode == TX_DATA)) begin
                    if (!txWord[bitCount]) begin
                        readPull <= 20;
                    end
                    bitCount <= bitCount + 4'd1;
                    if (bitCount == 4'd15) begin
                        mode <= IDLE;
                    end
                end
            end else if (busLine && (lowCycles > 0)) begin
                // master released the line
                lowCycles <= 0;
                if (lowCycles >= 480) begin
                    mode       <= RX_CMD;
                    bitCount   <= '0;
                    resetCount <= resetCount + 1;
                    if (presenceEnable) begin
                        presenceTimer <= 130;
                    end
                end else if (mode == RX_CMD) begin
                    // lsb first
                    rxShift  <= {rxBit, rxShift[15:1]};
                    bitCount <= bitCount + 4'd1;
                    if (bitCount == 4'd15) begin
                        cmdWord   <= {rxBit, rxShift[15:1]};
                        cmdStrobe <= 1'b1;
                        // read scratchpad hands the bus to the sensor
                        if ({rxBit, rxShift[15:9]} == 8'hBE) begin
                            mode   <= TX_DATA;
                            txWord <= rawWord;
                        end else begin
                            mode <= IDLE;
                        end
                    end
                end
            end
        end
    end

endmodule

// ==== ds18b20Driver.sv ====
`timescale 1ns/100ps

module ds18b20Driver #(
    parameter int convWaitUs = ds18b20Pkg::DEFAULT_CONV_WAIT_US
) (
    input  logic        clk1M,
    input  logic        rst,
    input  logic        busIn,
    output logic        busDrive,
    output logic [15:0] tempOut,
    output logic        tempNegative,
    output logic        sampleValid
);

    ds18b20Pkg::phase_e      phase;
    ds18b20Pkg::slotTiming_t timing;
    ds18b20Pkg::rawTemp_t    rawTemp;
    logic                    presenceSeen;
    logic                    rawValid;

    // counts within phase and slot
    slotTimer #(
        .convWaitUs(convWaitUs)
    ) timerInst (
        .clk1M (clk1M),
        .rst   (rst),
        .phase (phase),
        .timing(timing)
    );

    // reset, write, wait, reset, write, read loop
    oneWireSequencer seqInst (
        .clk1M       (clk1M),
        .rst         (rst),
        .timing      (timing),
        .presenceSeen(presenceSeen),
        .phase       (phase)
    );

    // open-drain pulls, presence and read shifting
    busBitEngine engineInst (
        .clk1M       (clk1M),
        .rst         (rst),
        .phase       (phase),
        .timing      (timing),
        .busIn       (busIn),
        .busDrive    (busDrive),
        .presenceSeen(presenceSeen),
        .rawTemp     (rawTemp),
        .rawValid    (rawValid)
    );

    // raw word to hundredths and sign
    tempScaler scalerInst (
        .clk1M       (clk1M),
        .rst         (rst),
        .rawTemp     (rawTemp),
        .rawValid    (rawValid),
        .tempOut     (tempOut),
        .tempNegative(tempNegative),
        .sampleValid (sampleValid)
    );

endmodule

// ==== tempScaler.sv ====
`timescale 1ns/100ps

module tempScaler (
    input  logic                 clk1M,
    input  logic                 rst,
    input  ds18b20Pkg::rawTemp_t rawTemp,
    input  logic                 rawValid,
    output logic [15:0]          tempOut,
    output logic                 tempNegative,
    output logic                 sampleValid
);

    logic        signBit;
    logic [10:0] magnitude;
    logic [20:0] product;
    logic [15:0] hundredths;

    // sign bits fill 15:11, magnitude sits in 10:0
    assign signBit   = rawTemp[15];
    assign magnitude = signBit ? (~rawTemp[10:0] + 11'd1) : rawTemp[10:0];

    // sixteenths times 6.25
    assign product    = magnitude * ds18b20Pkg::SCALE_NUM;
    assign hundredths = 16'(product / 21'(ds18b20Pkg::SCALE_DEN));

    always_ff @(posedge clk1M) begin
        if (!rst) begin
            tempOut      <= '0;
            tempNegative <= 1'b0;
            sampleValid  <= 1'b0;
        end else begin
            // one-cycle strobe, no back-pressure
            sampleValid <= rawValid;
            if (rawValid) begin
                tempOut      <= hundredths;
                tempNegative <= signBit;
            end
        end
    end

endmodule

// ==== busBitEngine.sv ====
`timescale 1ns/100ps

module busBitEngine (
    input  logic                    clk1M,
    input  logic                    rst,
    input  ds18b20Pkg::phase_e      phase,
    input  ds18b20Pkg::slotTiming_t timing,
    input  logic                    busIn,
    output logic                    busDrive,
    output logic                    presenceSeen,
    output ds18b20Pkg::rawTemp_t    rawTemp,
    output logic                    rawValid
);

    ds18b20Pkg::cmdWord_t cmdWord;
    ds18b20Pkg::usCount_t nextCount;
    ds18b20Pkg::rawTemp_t shiftReg;
    logic                 resetPhase;
    logic                 writePhase;
    logic                 slotEnd;
    logic                 cmdBit;
    logic                 driveNext;

    assign resetPhase = (phase == ds18b20Pkg::RESET_CONVERT) ||
                        (phase == ds18b20Pkg::RESET_READ);
    assign writePhase = (phase == ds18b20Pkg::WRITE_CONVERT) ||
                        (phase == ds18b20Pkg::WRITE_READ);
    assign slotEnd    = (writePhase || (phase == ds18b20Pkg::READ_DATA)) &&
                        (timing.usCount == ds18b20Pkg::SLOT_LAST_US);

    // command for this write phase, lsb first
    assign cmdWord = (phase == ds18b20Pkg::WRITE_READ) ? ds18b20Pkg::CMD_READ
                                                        : ds18b20Pkg::CMD_CONVERT;
    assign cmdBit  = cmdWord[timing.bitIndex];

    // drive level one cycle ahead, so the pin comes straight from a flop
    always_comb begin
        nextCount = timing.usCount + 1'b1;
        driveNext = 1'b0;
        if (timing.phaseDone) begin
            // every phase opens low except the conversion wait
            driveNext = (phase != ds18b20Pkg::WRITE_CONVERT);
        end else if (slotEnd) begin
            // lead-in of the following slot
            driveNext = 1'b1;
        end else if (resetPhase) begin
            driveNext = (nextCount <= ds18b20Pkg::RESET_LOW_LAST_US);
        end else if (writePhase) begin
            // a 0 bit holds low through count 61
            driveNext = (nextCount <= ds18b20Pkg::SLOT_LEAD_LAST_US) ||
                        (!cmdBit && (nextCount < ds18b20Pkg::SLOT_LAST_US));
        end else if (phase == ds18b20Pkg::READ_DATA) begin
            driveNext = (nextCount <= ds18b20Pkg::SLOT_LEAD_LAST_US);
        end
    end

    always_ff @(posedge clk1M) begin
        if (!rst) begin
            busDrive     <= 1'b0;
            presenceSeen <= 1'b0;
            rawValid     <= 1'b0;
        end else begin
            busDrive <= driveNext;
            // presence flag per reset phase
            if (resetPhase && (timing.usCount == '0)) begin
                presenceSeen <= 1'b0;
            end else if (resetPhase && (timing.usCount == ds18b20Pkg::PRESENCE_SAMPLE_US) &&
                         !busIn) begin
                presenceSeen <= 1'b1;
            end
            // strobe after the last read slot
            rawValid <= (phase == ds18b20Pkg::READ_DATA) && timing.phaseDone;
        end
    end

    // read bits enter at the top, first bit ends at bit 0
    always_ff @(posedge clk1M) begin
        if ((phase == ds18b20Pkg::READ_DATA) &&
            (timing.usCount == ds18b20Pkg::READ_SAMPLE_US)) begin
            shiftReg <= {busIn, shiftReg[15:1]};
        end
        if ((phase == ds18b20Pkg::READ_DATA) && timing.phaseDone) begin
            rawTemp <= shiftReg;
        end
    end

    // bus released while converting and when the sensor's read bit is sampled
    releasedWhenListening: assert property (@(posedge clk1M) disable iff (!rst)
        ((phase == ds18b20Pkg::CONVERSION_WAIT) ||
         ((phase == ds18b20Pkg::READ_DATA) &&
          (timing.usCount == ds18b20Pkg::READ_SAMPLE_US))) |-> !busDrive);

endmodule

// ==== oneWireSequencer.sv ====
`timescale 1ns/100ps

module oneWireSequencer (
    input  logic                    clk1M,
    input  logic                    rst,
    input  ds18b20Pkg::slotTiming_t timing,
    input  logic                    presenceSeen,
    output ds18b20Pkg::phase_e      phase
);

    ds18b20Pkg::phase_e nextPhase;

    // next phase, evaluated only when the timer ends the current one
    always_comb begin
        nextPhase = phase;
        if (timing.phaseDone) begin
            case (phase)
                ds18b20Pkg::RESET_CONVERT: begin
                    // no sensor answered, pulse again
                    if (presenceSeen) begin
                        nextPhase = ds18b20Pkg::WRITE_CONVERT;
                    end else begin
                        nextPhase = ds18b20Pkg::RESET_CONVERT;
                    end
                end
                ds18b20Pkg::WRITE_CONVERT: begin
                    nextPhase = ds18b20Pkg::CONVERSION_WAIT;
                end
                ds18b20Pkg::CONVERSION_WAIT: begin
                    nextPhase = ds18b20Pkg::RESET_READ;
                end
                ds18b20Pkg::RESET_READ: begin
                    // same retry rule as the first reset
                    if (presenceSeen) begin
                        nextPhase = ds18b20Pkg::WRITE_READ;
                    end else begin
                        nextPhase = ds18b20Pkg::RESET_READ;
                    end
                end
                ds18b20Pkg::WRITE_READ: begin
                    nextPhase = ds18b20Pkg::READ_DATA;
                end
                ds18b20Pkg::READ_DATA: begin
                    // word read, start the next measurement
                    nextPhase = ds18b20Pkg::RESET_CONVERT;
                end
                default: begin
                    nextPhase = ds18b20Pkg::RESET_CONVERT;
                end
            endcase
        end
    end

    // phase register
    always_ff @(posedge clk1M) begin
        if (!rst) begin
            phase <= ds18b20Pkg::RESET_CONVERT;
        end else begin
            phase <= nextPhase;
        end
    end

    // only the six defined phases ever appear
    phaseLegal: assert property (@(posedge clk1M) disable iff (!rst)
        phase inside {ds18b20Pkg::RESET_CONVERT, ds18b20Pkg::WRITE_CONVERT,
                      ds18b20Pkg::CONVERSION_WAIT, ds18b20Pkg::RESET_READ,
                      ds18b20Pkg::WRITE_READ, ds18b20Pkg::READ_DATA});

endmodule

// ==== slotTimer.sv ====
`timescale 1ns/100ps

module slotTimer #(
    parameter int convWaitUs = ds18b20Pkg::DEFAULT_CONV_WAIT_US
) (
    input  logic                    clk1M,
    input  logic                    rst,
    input  ds18b20Pkg::phase_e      phase,
    output ds18b20Pkg::slotTiming_t timing
);

    ds18b20Pkg::usCount_t  usCount;
    ds18b20Pkg::bitIndex_t bitIndex;
    logic                  resetPhase;
    logic                  slotPhase;
    logic                  waitPhase;
    logic                  slotEnd;
    logic                  phaseDone;

    // phase classes
    assign resetPhase = (phase == ds18b20Pkg::RESET_CONVERT) ||
                        (phase == ds18b20Pkg::RESET_READ);
    assign slotPhase  = (phase == ds18b20Pkg::WRITE_CONVERT) ||
                        (phase == ds18b20Pkg::WRITE_READ) ||
                        (phase == ds18b20Pkg::READ_DATA);
    assign waitPhase  = (phase == ds18b20Pkg::CONVERSION_WAIT);

    // last cycle of a 63 us slot
    assign slotEnd = slotPhase && (usCount == ds18b20Pkg::SLOT_LAST_US);

    // end of phase, the sequencer steps on the next edge
    assign phaseDone = (resetPhase && (usCount == ds18b20Pkg::RESET_PHASE_LAST_US)) ||
                       (slotEnd && (bitIndex == ds18b20Pkg::WORD_LAST_BIT)) ||
                       (waitPhase && (usCount == ds18b20Pkg::usCount_t'(convWaitUs)));

    always_ff @(posedge clk1M) begin
        if (!rst) begin
            usCount  <= '0;
            bitIndex <= '0;
        end else begin
            // restart at every slot and every phase boundary
            if (phaseDone || slotEnd) begin
                usCount <= '0;
            end else begin
                usCount <= usCount + 1'b1;
            end
            // wraps from 15 back to 0 at the end of the word
            if (slotEnd) begin
                bitIndex <= bitIndex + 1'b1;
            end
        end
    end

    assign timing = '{usCount: usCount, bitIndex: bitIndex, phaseDone: phaseDone};

    // bit counter only moves inside slot phases
    bitIdleOutsideSlots: assert property (@(posedge clk1M) disable iff (!rst)
        !slotPhase |-> (bitIndex == '0));

endmodule

// ==== ds18b20Pkg.sv ====
package ds18b20Pkg;

    // counter widths and payload types
    localparam int US_WIDTH = 20;

    typedef logic [US_WIDTH-1:0] usCount_t;
    typedef logic [3:0]          bitIndex_t;
    typedef logic [15:0]         rawTemp_t;
    typedef logic [15:0]         cmdWord_t;

    // bus phases in loop order
    typedef enum logic [2:0] {
        RESET_CONVERT,
        WRITE_CONVERT,
        CONVERSION_WAIT,
        RESET_READ,
        WRITE_READ,
        READ_DATA
    } phase_e;

    // position within the current phase, shared by sequencer and engine
    typedef struct packed {
        usCount_t  usCount;
        bitIndex_t bitIndex;
        logic      phaseDone;
    } slotTiming_t;

    // reset pulse timing, one count per microsecond
    localparam usCount_t RESET_LOW_LAST_US   = 20'd499;
    localparam usCount_t PRESENCE_SAMPLE_US  = 20'd570;
    localparam usCount_t RESET_PHASE_LAST_US = 20'd1000;

    // read and write slot timing
    localparam usCount_t SLOT_LEAD_LAST_US = 20'd1;
    localparam usCount_t READ_SAMPLE_US    = 20'd10;
    localparam usCount_t SLOT_LAST_US      = 20'd62;
    localparam bitIndex_t WORD_LAST_BIT    = 4'd15;

    // skip rom in the low byte, function command in the high byte
    localparam cmdWord_t CMD_CONVERT = 16'h44CC;
    localparam cmdWord_t CMD_READ    = 16'hBECC;

    // 1/16 degree steps to hundredths
    localparam logic [9:0] SCALE_NUM = 10'd625;
    localparam logic [6:0] SCALE_DEN = 7'd100;

    // 12-bit conversion worst case
    localparam int DEFAULT_CONV_WAIT_US = 780000;

endpackage
